// ==== rtl/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    localparam int ADDR_BITS = 7;   // 7-bit addressing only

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [7:0]           byte_t;

    // byte-level controller states
    typedef enum logic [2:0] {
        IDLE,
        START,
        ADDR,        // address plus r/w bit
        ACK1,        // target ack of address
        DATA,
        ACK2,        // data ack, ours on read
        STOP,
        WAIT_STOP    // until monitor sees the stop
    } i2c_state_e;

endpackage

`default_nettype wire

// ==== rtl/i2c_line_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface i2c_line_if;

    logic sda_sync;    // synchronized sda level
    logic scl_sync;    // synchronized scl level
    logic bus_busy;    // between a start and a stop
    logic stop_seen;   // one clock per stop condition

    modport monitor (
        output sda_sync,
        output scl_sync,
        output bus_busy,
        output stop_seen
    );

    modport master (
        input sda_sync,
        input scl_sync,
        input bus_busy,
        input stop_seen
    );

endinterface

`default_nettype wire

// ==== rtl/i2c_bit_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_timer #(
    parameter int CLK_DIV = 25
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic tick
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t RELOAD = cnt_t'(CLK_DIV - 1);

    cnt_t cnt;
    logic terminal;

    assign terminal = (cnt == '0);

    // quarter-bit counter, held at reload while stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= RELOAD;
            tick <= 1'b0;
        end else begin
            if (!run) begin
                cnt  <= RELOAD;   // next phase gets a full quarter
                tick <= 1'b0;
            end else if (terminal) begin
                cnt  <= RELOAD;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt - cnt_t'(1);
                tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2c_bus_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_bus_monitor (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sda_in,
    input  logic        scl_in,
    i2c_line_if.monitor line
);

    logic sda_meta;
    logic sda_sync;
    logic sda_prev;
    logic scl_meta;
    logic scl_sync;
    logic scl_prev;
    logic start_cond;
    logic stop_cond;
    logic busy;
    logic stop_pulse;

    // two-flop sync plus one history stage, idle bus reads high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
            sda_prev <= 1'b1;
            scl_meta <= 1'b1;
            scl_sync <= 1'b1;
            scl_prev <= 1'b1;
        end else begin
            sda_meta <= sda_in;
            sda_sync <= sda_meta;
            sda_prev <= sda_sync;
            scl_meta <= scl_in;
            scl_sync <= scl_meta;
            scl_prev <= scl_sync;
        end
    end

    // sda edge with scl steadily high
    assign start_cond = scl_sync && scl_prev && sda_prev && !sda_sync;
    assign stop_cond  = scl_sync && scl_prev && !sda_prev && sda_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            stop_pulse <= 1'b0;
        end else begin
            stop_pulse <= stop_cond;
            if (start_cond) begin
                busy <= 1'b1;   // ours or a foreign master
            end else if (stop_cond) begin
                busy <= 1'b0;
            end
        end
    end

    assign line.sda_sync  = sda_sync;
    assign line.scl_sync  = scl_sync;
    assign line.bus_busy  = busy;
    assign line.stop_seen = stop_pulse;

endmodule

`default_nettype wire

// ==== rtl/i2c_master_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_master_fsm (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           rw,
    input  i2c_pkg::addr_t dev_addr,
    input  i2c_pkg::byte_t data_tx,
    output i2c_pkg::byte_t data_rx,
    output logic           ack_error,
    output logic           done,
    output logic           sda_oe,
    output logic           scl_oe,
    input  logic           tick,
    output logic           run,
    i2c_line_if.master     line
);

    import i2c_pkg::*;

    i2c_state_e state;
    logic [1:0] phase;      // quarter-bit position
    logic [2:0] bit_cnt;
    byte_t      shift_reg;
    byte_t      data_q;
    logic       rw_q;
    logic       addr_nack;
    logic       stretch;    // scl released, not yet seen high
    logic       accept;
    logic       last_bit;
    logic       bit_sda_oe;

    assign accept   = (state == IDLE) && start && !line.bus_busy;
    assign last_bit = (bit_cnt == 3'd7);
    assign run      = (state != IDLE) && (state != WAIT_STOP) && !stretch;

    // sda drive for the data slot of the current bit
    always_comb begin
        case (state)
            ADDR:    bit_sda_oe = ~shift_reg[7];
            DATA:    bit_sda_oe = ~rw_q & ~shift_reg[7];
            default: bit_sda_oe = 1'b0;   // ack slots, let go
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= {dev_addr, rw};
            data_q    <= data_tx;
        end else if (tick) begin
            if (phase == 2'd2 && state == DATA && rw_q) begin
                shift_reg <= {shift_reg[6:0], line.sda_sync};   // msb first
            end else if (phase == 2'd3) begin
                if (state == ADDR || (state == DATA && !rw_q)) begin
                    shift_reg <= {shift_reg[6:0], 1'b0};
                end else if (state == ACK1 && !rw_q) begin
                    shift_reg <= data_q;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            phase     <= 2'd0;
            bit_cnt   <= 3'd0;
            rw_q      <= 1'b0;
            addr_nack <= 1'b0;
            stretch   <= 1'b0;
            sda_oe    <= 1'b0;
            scl_oe    <= 1'b0;
            data_rx   <= '0;
            ack_error <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (stretch && line.scl_sync) begin
                stretch <= 1'b0;   // target let scl go
            end
            case (state)
                IDLE: begin
                    if (accept) begin
                        rw_q      <= rw;
                        ack_error <= 1'b0;
                        addr_nack <= 1'b0;
                        phase     <= 2'd0;
                        bit_cnt   <= 3'd0;
                        state     <= START;
                    end
                end
                START: begin
                    if (tick) begin
                        if (phase == 2'd0) begin
                            sda_oe <= 1'b1;   // sda falls, scl high
                            phase  <= 2'd1;
                        end else begin
                            scl_oe <= 1'b1;
                            phase  <= 2'd0;
                            state  <= ADDR;
                        end
                    end
                end
                ADDR, ACK1, DATA, ACK2: begin
                    if (tick) begin
                        phase <= phase + 2'd1;
                        case (phase)
                            2'd0: sda_oe <= bit_sda_oe;
                            2'd1: begin
                                scl_oe  <= 1'b0;
                                stretch <= 1'b1;
                            end
                            2'd2: begin
                                if (state == ACK1 && line.sda_sync) begin
                                    addr_nack <= 1'b1;
                                    ack_error <= 1'b1;
                                end
                                if (state == ACK2) begin
                                    if (rw_q) begin
                                        data_rx <= shift_reg;
                                    end else if (line.sda_sync) begin
                                        ack_error <= 1'b1;
                                    end
                                end
                            end
                            default: begin
                                scl_oe <= 1'b1;   // end of bit
                                if (state == ADDR || state == DATA) begin
                                    bit_cnt <= bit_cnt + 3'd1;
                                end
                                if (state == ADDR && last_bit) begin
                                    state <= ACK1;
                                end else if (state == DATA && last_bit) begin
                                    state <= ACK2;
                                end else if (state == ACK1) begin
                                    if (addr_nack) begin
                                        state <= STOP;   // no data after a miss
                                    end else begin
                                        state <= DATA;
                                    end
                                end else if (state == ACK2) begin
                                    state <= STOP;
                                end
                            end
                        endcase
                    end
                end
                STOP: begin
                    if (tick) begin
                        case (phase)
                            2'd0: begin
                                sda_oe <= 1'b1;   // hold sda low under scl low
                                phase  <= 2'd1;
                            end
                            2'd1: begin
                                scl_oe  <= 1'b0;
                                stretch <= 1'b1;
                                phase   <= 2'd2;
                            end
                            default: begin
                                sda_oe <= 1'b0;   // sda rises, scl high
                                phase  <= 2'd0;
                                state  <= WAIT_STOP;
                            end
                        endcase
                    end
                end
                WAIT_STOP: begin
                    if (line.stop_seen) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2c_master_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_master_top #(
    parameter int CLK_DIV = 25
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           rw,
    input  i2c_pkg::addr_t dev_addr,
    input  i2c_pkg::byte_t data_tx,
    output i2c_pkg::byte_t data_rx,
    output logic           ack_error,
    output logic           done,
    output logic           bus_busy,
    input  logic           sda_in,
    input  logic           scl_in,
    output logic           sda_oe,
    output logic           scl_oe
);

    logic tick;
    logic run;

    i2c_line_if line_bus ();

    i2c_bit_timer #(
        .CLK_DIV (CLK_DIV)
    ) u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .tick  (tick)
    );

    i2c_bus_monitor u_monitor (
        .clk    (clk),
        .rst_n  (rst_n),
        .sda_in (sda_in),
        .scl_in (scl_in),
        .line   (line_bus.monitor)
    );

    i2c_master_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .rw        (rw),
        .dev_addr  (dev_addr),
        .data_tx   (data_tx),
        .data_rx   (data_rx),
        .ack_error (ack_error),
        .done      (done),
        .sda_oe    (sda_oe),
        .scl_oe    (scl_oe),
        .tick      (tick),
        .run       (run),
        .line      (line_bus.master)
    );

    assign bus_busy = line_bus.bus_busy;   // also set by other masters

endmodule

`default_nettype wire

// ==== tests/i2c_target_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_target_model (
    input  logic           clk,
    input  logic           sda,
    input  logic           scl,
    input  i2c_pkg::addr_t own_addr,
    input  i2c_pkg::byte_t read_byte,
    input  logic [7:0]     stretch_clks,   // 0 turns stretching off
    input  logic           ext_master,     // bus owned by a foreign master
    output logic           sda_pull,
    output logic           scl_pull,
    output i2c_pkg::addr_t rx_addr,
    output logic           rx_rw,
    output i2c_pkg::byte_t rx_data,
    output int             rx_count,
    output logic           master_nack
);

    import i2c_pkg::*;

    // sda only changes shortly after scl falls
    task automatic next_low_phase();
        @(negedge scl);
        #2;
    endtask

    task automatic serve_transfer();
        byte_t hdr;
        byte_t shifter;
        hdr = '0;
        repeat (8) begin
            @(posedge scl);
            hdr = {hdr[6:0], sda};
        end
        rx_addr = hdr[7:1];   // any address, ours or not
        rx_rw   = hdr[0];
        if (hdr[7:1] == own_addr) begin
            next_low_phase();
            sda_pull = 1'b1;   // address ack
            next_low_phase();
            if (rx_rw) begin
                master_nack = 1'b0;
                shifter     = read_byte;
                repeat (8) begin
                    sda_pull = ~shifter[7];   // msb first
                    shifter  = {shifter[6:0], 1'b0};
                    next_low_phase();
                end
                sda_pull = 1'b0;   // ack slot belongs to the master
                @(posedge scl);
                master_nack = sda;
            end else begin
                sda_pull = 1'b0;
                shifter  = '0;
                repeat (8) begin
                    @(posedge scl);
                    shifter = {shifter[6:0], sda};
                end
                next_low_phase();
                sda_pull = 1'b1;   // data ack
                next_low_phase();
                sda_pull = 1'b0;
                rx_data  = shifter;
                rx_count = rx_count + 1;
            end
        end
    endtask

    initial begin
        sda_pull    = 1'b0;
        rx_addr     = '0;
        rx_rw       = 1'b0;
        rx_data     = '0;
        rx_count    = 0;
        master_nack = 1'b0;
        forever begin
            @(negedge sda);
            if (scl === 1'b1 && !ext_master) begin   // start condition
                serve_transfer();
            end
        end
    end

    // hold scl low for a while after every falling edge
    initial begin
        scl_pull = 1'b0;
        forever begin
            @(negedge scl);
            if (stretch_clks != 8'd0) begin
                scl_pull = 1'b1;
                repeat (stretch_clks) @(posedge clk);
                #1;
                scl_pull = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_i2c_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_master;

    import i2c_pkg::*;

    localparam int    CLK_DIV      = 5;
    localparam int    DONE_TIMEOUT = 5000;
    localparam addr_t TGT_ADDR     = 7'h5a;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        rw;
    addr_t       dev_addr;
    byte_t       data_tx;
    byte_t       data_rx;
    logic        ack_error;
    logic        done;
    logic        bus_busy;
    logic        sda_oe;
    logic        scl_oe;
    logic        sda_line;
    logic        scl_line;
    logic        tgt_sda_pull;
    logic        tgt_scl_pull;
    logic        ext_sda_pull;   // foreign master on sda
    logic        ext_master;
    byte_t       read_byte;
    logic [7:0]  stretch_clks;
    addr_t       rx_addr;
    logic        rx_rw;
    byte_t       rx_data;
    int          rx_count;
    logic        master_nack;
    logic [31:0] rng_state;

    // wired-and bus
    assign sda_line = ~(sda_oe | tgt_sda_pull | ext_sda_pull);
    assign scl_line = ~(scl_oe | tgt_scl_pull);

    i2c_master_top #(
        .CLK_DIV (CLK_DIV)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .rw        (rw),
        .dev_addr  (dev_addr),
        .data_tx   (data_tx),
        .data_rx   (data_rx),
        .ack_error (ack_error),
        .done      (done),
        .bus_busy  (bus_busy),
        .sda_in    (sda_line),
        .scl_in    (scl_line),
        .sda_oe    (sda_oe),
        .scl_oe    (scl_oe)
    );

    i2c_target_model u_target (
        .clk          (clk),
        .sda          (sda_line),
        .scl          (scl_line),
        .own_addr     (TGT_ADDR),
        .read_byte    (read_byte),
        .stretch_clks (stretch_clks),
        .ext_master   (ext_master),
        .sda_pull     (tgt_sda_pull),
        .scl_pull     (tgt_scl_pull),
        .rx_addr      (rx_addr),
        .rx_rw        (rx_rw),
        .rx_data      (rx_data),
        .rx_count     (rx_count),
        .master_nack  (master_nack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_next();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        assert (got == expected) else begin
            report_error($sformatf("Fail at %0t: %s is 0x%0h, expected 0x%0h",
                                   $time, what, got, expected));
        end
    endtask

    task automatic pulse_start(input logic read, input addr_t addr, input byte_t data);
        rw       = read;
        dev_addr = addr;
        data_tx  = data;
        start    = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
            if (cycles > DONE_TIMEOUT) begin
                report_error($sformatf("timed out waiting for done at %0t", $time));
            end
        end
    endtask

    task automatic wait_bus_level(input logic level);
        int cycles;
        cycles = 0;
        while (bus_busy !== level) begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
            if (cycles > 100) begin
                report_error($sformatf("bus_busy never went to %0b, time %0t", level, $time));
            end
        end
    endtask

    // nothing may move on the dut side
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_value("sda_oe on a busy bus", int'(sda_oe), 0);
            check_value("scl_oe on a busy bus", int'(scl_oe), 0);
            check_value("done on a busy bus", int'(done), 0);
        end
    endtask

    task automatic run_write(input byte_t data);
        int count_before;
        count_before = rx_count;
        pulse_start(1'b0, TGT_ADDR, data);
        wait_done();
        check_value("ack_error after write", int'(ack_error), 0);
        check_value("target byte count", rx_count, count_before + 1);
        check_value("target data", int'(rx_data), int'(data));
        check_value("target address", int'(rx_addr), int'(TGT_ADDR));
        check_value("target r/w bit", int'(rx_rw), 0);
    endtask

    task automatic run_read(input byte_t value);
        read_byte = value;
        pulse_start(1'b1, TGT_ADDR, 8'h00);
        wait_done();
        check_value("ack_error after read", int'(ack_error), 0);
        check_value("data_rx", int'(data_rx), int'(value));
        check_value("target r/w bit", int'(rx_rw), 1);
        check_value("master ack on read data", int'(master_nack), 1);   // nack expected
    endtask

    task automatic run_miss(input logic read);
        int    count_before;
        byte_t rx_before;
        addr_t miss_addr;
        count_before = rx_count;
        rx_before    = data_rx;
        miss_addr    = TGT_ADDR ^ 7'h21;
        pulse_start(read, miss_addr, 8'hc3);
        wait_done();
        check_value("ack_error after address miss", int'(ack_error), 1);
        check_value("address sent on miss", int'(rx_addr), int'(miss_addr));
        check_value("r/w bit sent on miss", int'(rx_rw), int'(read));
        check_value("target byte count after miss", rx_count, count_before);
        check_value("data_rx after miss", int'(data_rx), int'(rx_before));
    endtask

    task automatic check_foreign_master();
        ext_master   = 1'b1;
        ext_sda_pull = 1'b1;   // start with scl idle high
        wait_bus_level(1'b1);
        pulse_start(1'b0, TGT_ADDR, 8'h3c);
        check_quiet(100);
        ext_sda_pull = 1'b0;   // stop
        wait_bus_level(1'b0);
        check_quiet(20);       // strobe must not be queued
        ext_master = 1'b0;
        run_write(byte_t'(rand_next()));
    endtask

    initial begin
        rng_state    = 32'd39843;
        rst_n        = 1'b0;
        start        = 1'b0;
        rw           = 1'b0;
        dev_addr     = TGT_ADDR;
        data_tx      = '0;
        ext_sda_pull = 1'b0;
        ext_master   = 1'b0;
        read_byte    = '0;
        stretch_clks = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_value("sda_oe after reset", int'(sda_oe), 0);
        check_value("scl_oe after reset", int'(scl_oe), 0);
        check_value("done after reset", int'(done), 0);
        check_value("ack_error after reset", int'(ack_error), 0);
        check_value("bus_busy after reset", int'(bus_busy), 0);
        check_value("data_rx after reset", int'(data_rx), 0);

        repeat (8) run_write(byte_t'(rand_next()));
        repeat (4) run_read(byte_t'(rand_next()));
        run_miss(1'b1);
        run_miss(1'b0);

        repeat (3) begin
            stretch_clks = 8'(32'd1 + rand_next() % 32'd40);
            run_write(byte_t'(rand_next()));
            stretch_clks = 8'(32'd1 + rand_next() % 32'd40);
            run_read(byte_t'(rand_next()));
        end
        stretch_clks = '0;

        check_foreign_master();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/i2c_pkg.sv
rtl/i2c_line_if.sv
rtl/i2c_bit_timer.sv
rtl/i2c_bus_monitor.sv
rtl/i2c_master_fsm.sv
rtl/i2c_master_top.sv
tests/i2c_target_model.sv
tests/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_i2c_master -Mdir obj_dir -f project.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_i2c_master > sim.log 2>&1

grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; }

grep -q "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "no result found in sim.log"; exit 1; }
